//--- sim.f
common/alu_pkg.sv
hw/alu/carry_lookahead_adder.sv
hw/alu/alu_core.sv
hw/alu/alu_stage.sv
hw/result_fifo.sv
hw/apb_front/apb_front.sv
hw/alu_coproc_top.sv
tests/tb_alu_coproc.sv

//--- Bender.yml
package:
  name: alu_coproc

sources:
  - common/alu_pkg.sv
  - hw/alu/carry_lookahead_adder.sv
  - hw/alu/alu_core.sv
  - hw/alu/alu_stage.sv
  - hw/result_fifo.sv
  - hw/apb_front/apb_front.sv
  - hw/alu_coproc_top.sv
  - target: test
    files:
      - tests/tb_alu_coproc.sv

//--- tests/tb_alu_coproc.sv
// testbench for the apb alu coprocessor with reference model and assertions
`timescale 1ns/1ns
`default_nettype none

module tb_alu_coproc;

    localparam int READY_LIMIT = 16;
    localparam int POLL_LIMIT  = 64;

    logic              clk;
    logic              rst;
    alu_pkg::apb_req_t apb_req;
    alu_pkg::apb_rsp_t apb_rsp;
    int                checks;
    int                errors;
    alu_pkg::data_t    exp_q[$];
    string             name_q[$];
    alu_pkg::data_t    edge_a [5] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h80000000,
                                      32'h7fffffff};
    alu_pkg::data_t    edge_b [5] = '{32'h0, 32'h0000001f, 32'h0, 32'hffffffff,
                                      32'h80000000};

    alu_coproc_top i_alu_coproc_top (
        .clk_i     (clk),
        .rst_i     (rst),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    always #20 clk = ~clk;

    pready_check: assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
        errors++;
        $display("pready was low during an APB access cycle");
    end

    quiet_err_check: assert property (@(posedge clk) disable iff (rst)
        !(apb_req.psel && apb_req.penable) |-> !apb_rsp.pslverr)
    else begin
        errors++;
        $display("pslverr was raised outside an APB access cycle");
    end

    function automatic alu_pkg::data_t model_result(input alu_pkg::alu_op_e op,
                                                    input alu_pkg::data_t a,
                                                    input alu_pkg::data_t b);
        int unsigned sh;
        sh = b[4:0];  // low five bits only.
        case (op)
            alu_pkg::OP_ADD:  return a + b;
            alu_pkg::OP_SUB:  return a - b;
            alu_pkg::OP_XOR:  return a ^ b;
            alu_pkg::OP_OR:   return a | b;
            alu_pkg::OP_AND:  return a & b;
            alu_pkg::OP_SLL:  return a << sh;
            alu_pkg::OP_SRL:  return a >> sh;
            alu_pkg::OP_SRA:  return $signed(a) >>> sh;
            alu_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            alu_pkg::OP_PASS: return b;
            default:          return '0;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Errors found");
        $finish;
    endtask

    task automatic check_value(input string name, input alu_pkg::data_t expected,
                               input alu_pkg::data_t actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic apb_transfer(input alu_pkg::addr_t addr, input logic write,
                                input alu_pkg::data_t wdata,
                                output alu_pkg::data_t rdata, output logic slverr);
        int cycles;
        cycles = 0;
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);  // mid access cycle.
        while (!apb_rsp.pready && cycles < READY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!apb_rsp.pready) begin
            abort_run("slave never raised pready");
        end else begin
            rdata  = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
            @(posedge clk);
            apb_req.psel    <= 1'b0;
            apb_req.penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input alu_pkg::addr_t addr, input alu_pkg::data_t data,
                             output logic slverr);
        alu_pkg::data_t unused;
        apb_transfer(addr, 1'b1, data, unused, slverr);
    endtask

    task automatic apb_read(input alu_pkg::addr_t addr, output alu_pkg::data_t data,
                            output logic slverr);
        apb_transfer(addr, 1'b0, '0, data, slverr);
    endtask

    task automatic wait_for_count(input int target, input string what);
        alu_pkg::data_t status;
        logic           err;
        int             polls;
        polls = 0;
        apb_read(alu_pkg::REG_STATUS, status, err);
        while (int'(status[7:4]) != target && polls < POLL_LIMIT) begin
            apb_read(alu_pkg::REG_STATUS, status, err);
            polls++;
        end
        if (int'(status[7:4]) != target) begin
            abort_run($sformatf("fifo count never reached %0d in %s", target, what));
        end
    endtask

    task automatic issue_cmd(input alu_pkg::alu_op_e op, input alu_pkg::data_t a,
                             input alu_pkg::data_t b);
        string name;
        logic  err;
        name = $sformatf("%s a=%h b=%h", op.name(), a, b);
        apb_write(alu_pkg::REG_OPA, a, err);
        check_value({name, " opa pslverr"}, '0, err);
        apb_write(alu_pkg::REG_OPB, b, err);
        check_value({name, " opb pslverr"}, '0, err);
        apb_write(alu_pkg::REG_CMD, alu_pkg::data_t'(op), err);
        check_value({name, " cmd pslverr"}, '0, err);
        exp_q.push_back(model_result(op, a, b));
        name_q.push_back(name);
    endtask

    task automatic read_result();
        alu_pkg::data_t rdata;
        alu_pkg::data_t expected;
        logic           err;
        string          name;
        expected = exp_q.pop_front();
        name     = name_q.pop_front();
        apb_read(alu_pkg::REG_RESULT, rdata, err);
        check_value({name, " result pslverr"}, '0, err);
        check_value(name, expected, rdata);
    endtask

    task automatic reset_state();
        alu_pkg::data_t rdata;
        logic           err;
        apb_read(alu_pkg::REG_STATUS, rdata, err);
        check_value("reset status", 32'h1, rdata);  // empty, count 0.
        check_value("reset status pslverr", '0, err);
        apb_read(alu_pkg::REG_OPA, rdata, err);
        check_value("reset opa", '0, rdata);
        apb_read(alu_pkg::REG_OPB, rdata, err);
        check_value("reset opb", '0, rdata);
    endtask

    task automatic opcode_sweep();
        alu_pkg::alu_op_e op;
        for (int i = 0; i <= 10; i++) begin
            op = alu_pkg::alu_op_e'(i);
            issue_cmd(op, $urandom(), $urandom());
            wait_for_count(1, "opcode test");
            read_result();
            for (int k = 0; k < 5; k++) begin
                issue_cmd(op, edge_a[k], edge_b[k]);
                wait_for_count(1, "edge operand test");
                read_result();
            end
        end
    endtask

    task automatic result_order();
        alu_pkg::data_t rdata;
        logic           err;
        for (int k = 0; k < 6; k++) begin
            issue_cmd(alu_pkg::alu_op_e'(2 * k), $urandom(), $urandom());
        end
        wait_for_count(6, "ordering test");
        for (int k = 0; k < 6; k++) begin
            apb_read(alu_pkg::REG_STATUS, rdata, err);
            check_value("ordering count", 6 - k, rdata[7:4]);
            read_result();
        end
    endtask

    task automatic fill_and_drain();
        alu_pkg::data_t rdata;
        logic           err;
        for (int k = 0; k < 9; k++) begin
            issue_cmd(alu_pkg::alu_op_e'(k % 11), $urandom(), $urandom());
            wait_for_count((k < 8) ? k + 1 : 8, "back-pressure fill");
        end
        apb_write(alu_pkg::REG_CMD, alu_pkg::data_t'(alu_pkg::OP_ADD), err);
        check_value("tenth cmd pslverr", 32'h1, err);
        apb_read(alu_pkg::REG_STATUS, rdata, err);
        check_value("full status", 32'h82, rdata);  // count 8 and full.
        for (int k = 0; k < 9; k++) begin
            wait_for_count((k == 0) ? 8 : 9 - k, "back-pressure drain");
            read_result();
        end
        apb_read(alu_pkg::REG_RESULT, rdata, err);
        check_value("empty read pslverr", 32'h1, err);
        check_value("empty read data", '0, rdata);
    endtask

    task automatic error_responses();
        alu_pkg::data_t rdata;
        logic           err;
        issue_cmd(alu_pkg::OP_OR, $urandom(), $urandom());
        wait_for_count(1, "error rule setup");
        for (int code = 11; code < 16; code++) begin
            apb_write(alu_pkg::REG_CMD, code, err);
            check_value($sformatf("illegal opcode %0d pslverr", code), 32'h1, err);
            apb_read(alu_pkg::REG_STATUS, rdata, err);
            check_value("count after illegal opcode", 32'h1, rdata[7:4]);
        end
        apb_write(8'h14, $urandom(), err);
        check_value("unmapped write pslverr", 32'h1, err);
        apb_read(8'h40, rdata, err);
        check_value("unmapped read pslverr", 32'h1, err);
        apb_write(alu_pkg::REG_STATUS, $urandom(), err);
        check_value("status write pslverr", 32'h1, err);
        apb_write(alu_pkg::REG_RESULT, $urandom(), err);
        check_value("result write pslverr", 32'h1, err);
        read_result();  // the legal one is still there.
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        apb_req = '0;
        checks  = 0;
        errors  = 0;
        void'($urandom(32'h3b69));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        opcode_sweep();
        result_order();
        fill_and_drain();
        error_responses();
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/alu_coproc_top.sv
// top level wiring the apb front, alu stage and result fifo
`timescale 1ns/1ns
`default_nettype none

module alu_coproc_top (
    input  wire                clk_i,
    input  wire                rst_i,
    input  alu_pkg::apb_req_t  apb_req_i,
    output alu_pkg::apb_rsp_t  apb_rsp_o
);

    alu_pkg::alu_cmd_t cmd;
    logic              cmd_valid;
    logic              cmd_ready;
    alu_pkg::data_t    res_data;
    logic              res_valid;
    logic              push_ready;
    alu_pkg::data_t    head;
    logic              fifo_empty;
    logic              fifo_full;
    alu_pkg::count_t   fifo_count;
    logic              pop;

    apb_front i_apb_front (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .cmd_o        (cmd),
        .cmd_valid_o  (cmd_valid),
        .cmd_ready_i  (cmd_ready),
        .res_data_i   (head),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fifo_count_i (fifo_count),
        .pop_o        (pop)
    );

    alu_stage i_alu_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd),
        .cmd_valid_i  (cmd_valid),
        .cmd_ready_o  (cmd_ready),
        .res_data_o   (res_data),
        .res_valid_o  (res_valid),
        .push_ready_i (push_ready)
    );

    result_fifo i_result_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_i       (res_valid),
        .push_data_i  (res_data),
        .push_ready_o (push_ready),
        .pop_i        (pop),
        .head_o       (head),
        .empty_o      (fifo_empty),
        .full_o       (fifo_full),
        .count_o      (fifo_count)
    );

endmodule

`default_nettype wire

//--- hw/apb_front/apb_front.sv
// apb slave with operand registers, command issue, result pop and status read
`timescale 1ns/1ns
`default_nettype none

module apb_front (
    input  wire                clk_i,
    input  wire                rst_i,
    input  alu_pkg::apb_req_t  apb_req_i,
    output alu_pkg::apb_rsp_t  apb_rsp_o,
    output alu_pkg::alu_cmd_t  cmd_o,
    output logic               cmd_valid_o,
    input  wire                cmd_ready_i,
    input  alu_pkg::data_t     res_data_i,
    input  wire                fifo_empty_i,
    input  wire                fifo_full_i,
    input  alu_pkg::count_t    fifo_count_i,
    output logic               pop_o
);

    alu_pkg::addr_t addr;
    alu_pkg::data_t opa_q;
    alu_pkg::data_t opb_q;
    alu_pkg::data_t rdata;
    logic           access;
    logic           wr_en;
    logic           rd_en;
    logic           hit_opa;
    logic           hit_opb;
    logic           hit_cmd;
    logic           hit_result;
    logic           hit_status;
    logic           mapped;
    logic           op_legal;
    logic           err;

    assign addr   = apb_req_i.paddr;
    assign access = apb_req_i.psel & apb_req_i.penable;  // no wait states.
    assign wr_en  = access & apb_req_i.pwrite;
    assign rd_en  = access & ~apb_req_i.pwrite;

    assign hit_opa    = (addr == alu_pkg::REG_OPA);
    assign hit_opb    = (addr == alu_pkg::REG_OPB);
    assign hit_cmd    = (addr == alu_pkg::REG_CMD);
    assign hit_result = (addr == alu_pkg::REG_RESULT);
    assign hit_status = (addr == alu_pkg::REG_STATUS);
    assign mapped     = hit_opa | hit_opb | hit_cmd | hit_result | hit_status;

    assign op_legal = (apb_req_i.pwdata[3:0] <= 4'(alu_pkg::OP_PASS));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            opa_q <= '0;
            opb_q <= '0;
        end else if (wr_en) begin
            if (hit_opa) begin
                opa_q <= apb_req_i.pwdata;
            end
            if (hit_opb) begin
                opb_q <= apb_req_i.pwdata;
            end
        end
    end

    // command is built from the live write data.
    assign cmd_o.op     = alu_pkg::alu_op_e'(apb_req_i.pwdata[3:0]);
    assign cmd_o.a      = opa_q;
    assign cmd_o.b      = opb_q;
    assign cmd_valid_o  = wr_en & hit_cmd & op_legal;

    assign pop_o = rd_en & hit_result & ~fifo_empty_i;

    always_comb begin
        rdata = '0;
        if (rd_en) begin
            if (hit_opa) begin
                rdata = opa_q;
            end else if (hit_opb) begin
                rdata = opb_q;
            end else if (hit_result && !fifo_empty_i) begin
                rdata = res_data_i;  // head is popped at the edge.
            end else if (hit_status) begin
                rdata = {24'b0, fifo_count_i, 2'b00, fifo_full_i, fifo_empty_i};
            end
        end
    end

    always_comb begin
        err = 1'b0;
        if (access) begin
            if (!mapped) begin
                err = 1'b1;
            end else if (apb_req_i.pwrite && (hit_result || hit_status)) begin
                err = 1'b1;  // read only.
            end else if (wr_en && hit_cmd && (!op_legal || !cmd_ready_i)) begin
                err = 1'b1;  // bad opcode or stage busy.
            end else if (rd_en && hit_result && fifo_empty_i) begin
                err = 1'b1;
            end
        end
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = err;

endmodule

`default_nettype wire

//--- hw/result_fifo.sv
// first-word-fall-through result fifo with occupancy count
`timescale 1ns/1ns
`default_nettype none

module result_fifo (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              push_i,
    input  alu_pkg::data_t   push_data_i,
    output logic             push_ready_o,
    input  wire              pop_i,
    output alu_pkg::data_t   head_o,
    output logic             empty_o,
    output logic             full_o,
    output alu_pkg::count_t  count_o
);

    alu_pkg::data_t              mem [alu_pkg::FIFO_DEPTH];
    logic [alu_pkg::PTR_W-1:0]   wr_ptr_q;
    logic [alu_pkg::PTR_W-1:0]   rd_ptr_q;
    alu_pkg::count_t             count_q;
    logic                        do_push;
    logic                        do_pop;

    assign empty_o      = (count_q == '0);
    assign full_o       = (count_q == alu_pkg::count_t'(alu_pkg::FIFO_DEPTH));
    assign push_ready_o = ~full_o;
    assign count_o      = count_q;
    assign head_o       = mem[rd_ptr_q];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers wrap on their own width.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/alu/alu_stage.sv
// one-stage execute pipeline with alu and held result under a valid flag
`timescale 1ns/1ns
`default_nettype none

module alu_stage (
    input  wire                clk_i,
    input  wire                rst_i,
    input  alu_pkg::alu_cmd_t  cmd_i,
    input  wire                cmd_valid_i,
    output logic               cmd_ready_o,
    output alu_pkg::data_t     res_data_o,
    output logic               res_valid_o,
    input  wire                push_ready_i
);

    alu_pkg::data_t alu_result;
    alu_pkg::data_t res_q;
    logic           valid_q;
    logic           accept;

    alu_core i_alu_core (
        .op_i     (cmd_i.op),
        .a_i      (cmd_i.a),
        .b_i      (cmd_i.b),
        .result_o (alu_result)
    );

    // free slot, or the held result leaves this cycle.
    assign cmd_ready_o = ~valid_q | push_ready_i;
    assign accept      = cmd_valid_i & cmd_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (push_ready_i) begin
            valid_q <= 1'b0;  // pushed.
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q <= alu_result;
        end
    end

    assign res_data_o  = res_q;
    assign res_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hw/alu/alu_core.sv
// combinational alu over the eleven opcodes
`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::data_t   a_i,
    input  alu_pkg::data_t   b_i,
    output alu_pkg::data_t   result_o
);

    alu_pkg::data_t                 add_b;
    alu_pkg::data_t                 add_sum;
    alu_pkg::data_t                 res_sll;
    alu_pkg::data_t                 res_srl;
    alu_pkg::data_t                 res_sra;
    alu_pkg::data_t                 res_slt;
    alu_pkg::data_t                 res_sltu;
    logic [alu_pkg::SHAMT_W-1:0]    shamt;
    logic                           is_sub;

    assign is_sub = (op_i == alu_pkg::OP_SUB);
    assign add_b  = is_sub ? ~b_i : b_i;  // two's complement with carry-in.

    carry_lookahead_adder i_cla (
        .a_i     (a_i),
        .b_i     (add_b),
        .carry_i (is_sub),
        .sum_o   (add_sum)
    );

    assign shamt = b_i[alu_pkg::SHAMT_W-1:0];

    assign res_sll  = a_i << shamt;
    assign res_srl  = a_i >> shamt;
    assign res_sra  = alu_pkg::data_t'($signed(a_i) >>> shamt);
    assign res_slt  = ($signed(a_i) < $signed(b_i)) ? 32'd1 : 32'd0;
    assign res_sltu = (a_i < b_i) ? 32'd1 : 32'd0;

    always_comb begin
        case (op_i)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB:  result_o = add_sum;
            alu_pkg::OP_XOR:  result_o = a_i ^ b_i;
            alu_pkg::OP_OR:   result_o = a_i | b_i;
            alu_pkg::OP_AND:  result_o = a_i & b_i;
            alu_pkg::OP_SLL:  result_o = res_sll;
            alu_pkg::OP_SRL:  result_o = res_srl;
            alu_pkg::OP_SRA:  result_o = res_sra;
            alu_pkg::OP_SLT:  result_o = res_slt;
            alu_pkg::OP_SLTU: result_o = res_sltu;
            alu_pkg::OP_PASS: result_o = b_i;
            default:          result_o = '0;  // rejected by the front.
        endcase
    end

endmodule

`default_nettype wire

//--- hw/alu/carry_lookahead_adder.sv
// 32-bit carry-lookahead adder from eight 4-bit lookahead groups
`timescale 1ns/1ns
`default_nettype none

module carry_lookahead_adder (
    input  alu_pkg::data_t a_i,
    input  alu_pkg::data_t b_i,
    input  wire            carry_i,
    output alu_pkg::data_t sum_o
);

    alu_pkg::data_t g;
    alu_pkg::data_t p;
    alu_pkg::data_t c;  // carry into each bit.

    assign g    = a_i & b_i;
    assign p    = a_i ^ b_i;
    assign c[0] = carry_i;

    for (genvar gi = 0; gi < 8; gi++) begin : gen_group
        // lookahead from the group carry-in.
        assign c[gi*4+1] = g[gi*4]
                         | (p[gi*4] & c[gi*4]);
        assign c[gi*4+2] = g[gi*4+1]
                         | (p[gi*4+1] & g[gi*4])
                         | (p[gi*4+1] & p[gi*4] & c[gi*4]);
        assign c[gi*4+3] = g[gi*4+2]
                         | (p[gi*4+2] & g[gi*4+1])
                         | (p[gi*4+2] & p[gi*4+1] & g[gi*4])
                         | (p[gi*4+2] & p[gi*4+1] & p[gi*4] & c[gi*4]);

        // group carry ripples to the next group.
        if (gi < 7) begin : gen_ripple
            assign c[gi*4+4] = g[gi*4+3]
                             | (p[gi*4+3] & g[gi*4+2])
                             | (p[gi*4+3] & p[gi*4+2] & g[gi*4+1])
                             | (p[gi*4+3] & p[gi*4+2] & p[gi*4+1] & g[gi*4])
                             | (p[gi*4+3] & p[gi*4+2] & p[gi*4+1] & p[gi*4]
                                & c[gi*4]);
        end
    end

    assign sum_o = p ^ c;

endmodule

`default_nettype wire

//--- common/alu_pkg.sv
// widths, opcode enum, apb and command structs, register offsets, fifo depth
`default_nettype none

package alu_pkg;

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 8;
    localparam int OP_W       = 4;
    localparam int COUNT_W    = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = 3;  // log2 of fifo depth.
    localparam int SHAMT_W    = 5;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COUNT_W-1:0] count_t;

    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_XOR  = 4'd2,
        OP_OR   = 4'd3,
        OP_AND  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_PASS = 4'd10  // returns operand b.
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        data_t   a;
        data_t   b;
    } alu_cmd_t;

    typedef struct packed {
        addr_t paddr;
        logic  psel;
        logic  penable;
        logic  pwrite;
        data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    localparam addr_t REG_OPA    = 8'h00;
    localparam addr_t REG_OPB    = 8'h04;
    localparam addr_t REG_CMD    = 8'h08;  // opcode in bits 3:0.
    localparam addr_t REG_RESULT = 8'h0C;  // read pops the fifo.
    localparam addr_t REG_STATUS = 8'h10;

endpackage

`default_nettype wire
